// File: include/pvt_defines.svh
// Physical register valid tracker sizes
// Shared by the package and every block of the tracker

`ifndef PVT_DEFINES_SVH
`define PVT_DEFINES_SVH

// ========================================
// Storage shape
// ========================================

// Physical registers per checkpoint
`define PVT_PREGS 64

// Rename checkpoints, one valid table each
`define PVT_NCHECK 4

// ========================================
// Port counts
// ========================================

// Write ports, one bank per port
`define PVT_NWPORT 4

// Read ports, two per instruction (source A, source B)
`define PVT_NRPORT 8

// Instructions per read group, half of PVT_NRPORT
`define PVT_NINST 4

`endif

// File: source/pvt_pkg.sv
// Types for the physical register valid tracker
// Register, checkpoint and bank numbers plus the read result word

`include "pvt_defines.svh"

package pvt_pkg;

   // ========================================
   // Index types
   // ========================================

   // Physical register number
   typedef logic [$clog2(`PVT_PREGS)-1:0] pregno_t;

   // Checkpoint number
   typedef logic [$clog2(`PVT_NCHECK)-1:0] chkno_t;

   // Bank holding the latest value of an entry (the LVT entry)
   typedef logic [$clog2(`PVT_NWPORT)-1:0] bankno_t;

   // ========================================
   // Read result word
   // ========================================

   // Same bits seen two ways
   // ports view has bit p as the valid bit of read port p
   // pairs view has pairs[k][0] as source A and pairs[k][1] as source B of instruction k
   typedef union packed {
      logic [`PVT_NRPORT-1:0]     ports;   // Written by the RAM
      logic [`PVT_NINST-1:0][1:0] pairs;   // Read by the gather block
   } valid_word_u;

endpackage

// File: source/valid_write_stage.sv
// Write staging for the valid tracker
// Drops lower-port writes that collide on the same entry, then registers the rest

`include "pvt_defines.svh"

module valid_write_stage (
   input  logic                                  clka,
   input  logic                                  rst_n,
   input  logic             [`PVT_NWPORT-1:0]    wr_stb,    // One strobe per port
   input  pvt_pkg::chkno_t  [`PVT_NWPORT-1:0]    wr_chk,
   input  pvt_pkg::pregno_t [`PVT_NWPORT-1:0]    wr_preg,
   input  logic             [`PVT_NWPORT-1:0]    wr_val,    // 0 on allocate, 1 on writeback
   output logic             [`PVT_NWPORT-1:0]    ram_we,
   output pvt_pkg::chkno_t  [`PVT_NWPORT-1:0]    ram_wc,
   output pvt_pkg::pregno_t [`PVT_NWPORT-1:0]    ram_wa,
   output logic             [`PVT_NWPORT-1:0]    ram_wd
);

   logic [`PVT_NWPORT-1:0] wr_win;   // Strobes that survive conflict check

   // ========================================
   // Conflict resolution
   // ========================================

   // A port loses if any higher strobed port names the same entry
   always_comb begin
      for (int i = 0; i < `PVT_NWPORT; i++) begin
         wr_win[i] = wr_stb[i];
         for (int j = i + 1; j < `PVT_NWPORT; j++) begin
            if (wr_stb[j] && (wr_chk[j] == wr_chk[i]) && (wr_preg[j] == wr_preg[i])) begin
               wr_win[i] = 1'b0;   // Higher port overrides
            end
         end
      end
   end

   // ========================================
   // Staging registers
   // ========================================

   // Write enables, cleared by reset
   always_ff @(posedge clka) begin
      if (!rst_n) begin
         ram_we <= '0;
      end else begin
         ram_we <= wr_win;
      end
   end

   // Address and data follow the strobe, qualified by ram_we downstream
   always_ff @(posedge clka) begin
      ram_wc <= wr_chk;
      ram_wa <= wr_preg;
      ram_wd <= wr_val;
   end

endmodule

// File: source/checkpoint_valid_ram.sv
// Checkpoint valid RAM
// One bank per write port, each bank kept twice so each copy serves half the reads
// The live-value table picks the bank that last wrote each entry

`include "pvt_defines.svh"

module checkpoint_valid_ram (
   input  logic                                  clka,
   input  logic                                  rst_n,
   input  logic             [`PVT_NWPORT-1:0]    ram_we,
   input  pvt_pkg::chkno_t  [`PVT_NWPORT-1:0]    ram_wc,
   input  pvt_pkg::pregno_t [`PVT_NWPORT-1:0]    ram_wa,
   input  logic             [`PVT_NWPORT-1:0]    ram_wd,
   input  logic                                  rd_stb,    // Whole read group
   input  pvt_pkg::chkno_t  [`PVT_NRPORT-1:0]    rd_chk,
   input  pvt_pkg::pregno_t [`PVT_NRPORT-1:0]    rd_preg,
   output pvt_pkg::valid_word_u                  rd_word,   // Registered result
   output logic                                  rd_hit     // rd_stb one cycle later
);

   // Entry index is checkpoint above register
   localparam int IDX_W = $bits(pvt_pkg::chkno_t) + $bits(pvt_pkg::pregno_t);
   localparam int NENT  = `PVT_NCHECK * `PVT_PREGS;
   localparam int HALF  = `PVT_NRPORT / 2;   // First port served by copy B

   // ========================================
   // Storage
   // ========================================

   logic [`PVT_NWPORT-1:0][NENT-1:0] copy_a;   // Banks for read ports 0..HALF-1
   logic [`PVT_NWPORT-1:0][NENT-1:0] copy_b;   // Banks for read ports HALF..NRPORT-1
   pvt_pkg::bankno_t [NENT-1:0]      lvt;      // Latest writer per entry

   // Read side address and bank select per port
   logic             [IDX_W-1:0]      rd_addr [`PVT_NRPORT];
   pvt_pkg::bankno_t                  rd_bank [`PVT_NRPORT];
   logic             [`PVT_NRPORT-1:0] rd_bit;

   // ========================================
   // Write side
   // ========================================

   // Staging already removed same-entry collisions
   always_ff @(posedge clka) begin
      if (!rst_n) begin
         lvt       <= '0;   // All entries point at bank 0
         copy_a[0] <= '1;   // Bank 0 starts all valid
         copy_b[0] <= '1;
      end else begin
         for (int b = 0; b < `PVT_NWPORT; b++) begin
            if (ram_we[b]) begin
               copy_a[b][{ram_wc[b], ram_wa[b]}] <= ram_wd[b];   // Both copies together
               copy_b[b][{ram_wc[b], ram_wa[b]}] <= ram_wd[b];
               lvt[{ram_wc[b], ram_wa[b]}]       <= pvt_pkg::bankno_t'(b);
            end
         end
      end
   end

   // ========================================
   // Read side
   // ========================================

   // LVT lookup, then the selected bank's copy for this half
   always_comb begin
      for (int p = 0; p < `PVT_NRPORT; p++) begin
         rd_addr[p] = {rd_chk[p], rd_preg[p]};
         rd_bank[p] = lvt[rd_addr[p]];
         if (p < HALF) begin
            rd_bit[p] = copy_a[rd_bank[p]][rd_addr[p]];
         end else begin
            rd_bit[p] = copy_b[rd_bank[p]][rd_addr[p]];
         end
      end
   end

   // Result register, all valid out of reset
   always_ff @(posedge clka) begin
      if (!rst_n) begin
         rd_word.ports <= '1;
         rd_hit        <= 1'b0;
      end else begin
         rd_word.ports <= rd_bit;   // Written through ports view
         rd_hit        <= rd_stb;
      end
   end

endmodule

// File: source/operand_ready_gather.sv
// Operand ready gathering
// Turns the RAM read word into per-source valid bits and per-instruction ready

`include "pvt_defines.svh"

module operand_ready_gather (
   input  logic                          clka,
   input  logic                          rst_n,
   input  pvt_pkg::valid_word_u          rd_word,      // Registered by the RAM
   input  logic                          rd_hit,
   input  logic [`PVT_NINST-1:0]         rd_one_src,   // Same cycle as rd_stb
   output logic                          rdy_stb,
   output logic [`PVT_NRPORT-1:0]        src_valid,
   output logic [`PVT_NINST-1:0]         inst_rdy
);

   logic [`PVT_NINST-1:0] one_src_q;   // Lined up with rd_word

   // ========================================
   // Alignment
   // ========================================

   // RAM result lands one cycle after the address
   always_ff @(posedge clka) begin
      if (!rst_n) begin
         one_src_q <= '0;
      end else begin
         one_src_q <= rd_one_src;
      end
   end

   // ========================================
   // Readiness
   // ========================================

   assign rdy_stb   = rd_hit;          // Fixed latency of one
   assign src_valid = rd_word.ports;   // Per read port

   // Source A always counts, source B unless one-source
   always_comb begin
      for (int k = 0; k < `PVT_NINST; k++) begin
         inst_rdy[k] = rd_word.pairs[k][0] & (rd_word.pairs[k][1] | one_src_q[k]);
      end
   end

endmodule

// File: source/preg_valid_tracker.sv
// Physical register valid tracker, top level
// Write staging, banked checkpoint RAM and ready gathering on one clock

`include "pvt_defines.svh"

module preg_valid_tracker (
   input  logic                                  clka,
   input  logic                                  rst_n,
   // Write ports, allocate clears and writeback sets
   input  logic             [`PVT_NWPORT-1:0]    wr_stb,
   input  pvt_pkg::chkno_t  [`PVT_NWPORT-1:0]    wr_chk,
   input  pvt_pkg::pregno_t [`PVT_NWPORT-1:0]    wr_preg,
   input  logic             [`PVT_NWPORT-1:0]    wr_val,
   // Read group
   input  logic                                  rd_stb,
   input  pvt_pkg::chkno_t  [`PVT_NRPORT-1:0]    rd_chk,
   input  pvt_pkg::pregno_t [`PVT_NRPORT-1:0]    rd_preg,
   input  logic             [`PVT_NINST-1:0]     rd_one_src,
   // Results, one cycle after rd_stb
   output logic                                  rdy_stb,
   output logic             [`PVT_NRPORT-1:0]    src_valid,
   output logic             [`PVT_NINST-1:0]     inst_rdy
);

   // ========================================
   // Internal wires
   // ========================================

   logic             [`PVT_NWPORT-1:0] ram_we;   // Staged writes
   pvt_pkg::chkno_t  [`PVT_NWPORT-1:0] ram_wc;
   pvt_pkg::pregno_t [`PVT_NWPORT-1:0] ram_wa;
   logic             [`PVT_NWPORT-1:0] ram_wd;
   pvt_pkg::valid_word_u               rd_word;  // RAM result
   logic                               rd_hit;

   // Input side
   valid_write_stage valid_write_stage_inst (
      .clka    (clka),
      .rst_n   (rst_n),
      .wr_stb  (wr_stb),
      .wr_chk  (wr_chk),
      .wr_preg (wr_preg),
      .wr_val  (wr_val),
      .ram_we  (ram_we),
      .ram_wc  (ram_wc),
      .ram_wa  (ram_wa),
      .ram_wd  (ram_wd)
   );

   // Processing, banked valid memory
   checkpoint_valid_ram checkpoint_valid_ram_inst (
      .clka    (clka),
      .rst_n   (rst_n),
      .ram_we  (ram_we),
      .ram_wc  (ram_wc),
      .ram_wa  (ram_wa),
      .ram_wd  (ram_wd),
      .rd_stb  (rd_stb),
      .rd_chk  (rd_chk),
      .rd_preg (rd_preg),
      .rd_word (rd_word),
      .rd_hit  (rd_hit)
   );

   // Output side
   operand_ready_gather operand_ready_gather_inst (
      .clka       (clka),
      .rst_n      (rst_n),
      .rd_word    (rd_word),
      .rd_hit     (rd_hit),
      .rd_one_src (rd_one_src),
      .rdy_stb    (rdy_stb),
      .src_valid  (src_valid),
      .inst_rdy   (inst_rdy)
   );

endmodule

// File: tests/tb_preg_valid_tracker.sv
// Testbench for the physical register valid tracker
// Directed tasks against a reference valid table per checkpoint

`include "pvt_defines.svh"

module tb_preg_valid_tracker;

   localparam int RESP_TIMEOUT = 20;   // Cycles allowed for rdy_stb
   localparam int WINDOW       = 16;   // Small register window for more overlaps

   typedef logic [`PVT_NWPORT-1:0] wvec_t;
   typedef logic [`PVT_NINST-1:0]  ivec_t;

   logic                                  clka;
   logic                                  rst_n;
   logic             [`PVT_NWPORT-1:0]    wr_stb;
   pvt_pkg::chkno_t  [`PVT_NWPORT-1:0]    wr_chk;
   pvt_pkg::pregno_t [`PVT_NWPORT-1:0]    wr_preg;
   logic             [`PVT_NWPORT-1:0]    wr_val;
   logic                                  rd_stb;
   pvt_pkg::chkno_t  [`PVT_NRPORT-1:0]    rd_chk;
   pvt_pkg::pregno_t [`PVT_NRPORT-1:0]    rd_preg;
   logic             [`PVT_NINST-1:0]     rd_one_src;
   logic                                  rdy_stb;
   logic             [`PVT_NRPORT-1:0]    src_valid;
   logic             [`PVT_NINST-1:0]     inst_rdy;

   logic ref_tbl [`PVT_NCHECK][`PVT_PREGS];   // Reference valid table

   preg_valid_tracker preg_valid_tracker_inst (
      .clka       (clka),
      .rst_n      (rst_n),
      .wr_stb     (wr_stb),
      .wr_chk     (wr_chk),
      .wr_preg    (wr_preg),
      .wr_val     (wr_val),
      .rd_stb     (rd_stb),
      .rd_chk     (rd_chk),
      .rd_preg    (rd_preg),
      .rd_one_src (rd_one_src),
      .rdy_stb    (rdy_stb),
      .src_valid  (src_valid),
      .inst_rdy   (inst_rdy)
   );

   initial begin
      clka = 1'b0;
      forever #50 clka = ~clka;   // Period 100
   end

   // ========================================
   // Reporting and compare
   // ========================================

   task automatic stop_run(input string line);
      $display("%s", line);
      $display("Regression failed");
      $fatal(1, "stopped at first error");
   endtask

   // Per-port valid bits through the ports view
   task automatic check_word(input string name, input pvt_pkg::valid_word_u got,
                             input pvt_pkg::valid_word_u exp);
      if (got.ports !== exp.ports) begin
         stop_run($sformatf("error at time %0t: %s got %h expected %h",
                            $time, name, got.ports, exp.ports));
      end
   endtask

   // Per-instruction ready vector
   task automatic expect_ready(input string name, input ivec_t got, input ivec_t exp);
      if (got !== exp) begin
         stop_run($sformatf("error at time %0t: %s got %h expected %h",
                            $time, name, got, exp));
      end
   endtask

   // ========================================
   // Write and read drivers
   // ========================================

   // One write cycle with the model applying ports in order so the highest wins
   task automatic write_cycle(input wvec_t stb, input pvt_pkg::chkno_t [`PVT_NWPORT-1:0] c,
                              input pvt_pkg::pregno_t [`PVT_NWPORT-1:0] r, input wvec_t v);
      @(posedge clka);
      wr_stb  <= stb;
      wr_chk  <= c;
      wr_preg <= r;
      wr_val  <= v;
      for (int i = 0; i < `PVT_NWPORT; i++) begin
         if (stb[i]) ref_tbl[c[i]][r[i]] = v[i];
      end
   endtask

   // Single strobed port, all others idle
   task automatic single_write(input int port, input pvt_pkg::chkno_t c,
                               input pvt_pkg::pregno_t r, input logic v);
      pvt_pkg::chkno_t  [`PVT_NWPORT-1:0] cv;
      pvt_pkg::pregno_t [`PVT_NWPORT-1:0] rv;
      wvec_t stb;
      wvec_t val;
      cv = '0;
      rv = '0;
      stb = '0;
      val = '0;
      cv[port] = c;
      rv[port] = r;
      stb[port] = 1'b1;
      val[port] = v;
      write_cycle(stb, cv, rv, val);
   endtask

   // Drop strobes, then two cycles so the write reaches the RAM
   task automatic settle();
      @(posedge clka);
      wr_stb <= '0;
      repeat (2) @(posedge clka);
   endtask

   task automatic read_group(input pvt_pkg::chkno_t [`PVT_NRPORT-1:0] c,
                             input pvt_pkg::pregno_t [`PVT_NRPORT-1:0] r, input ivec_t one);
      pvt_pkg::valid_word_u exp_word;
      pvt_pkg::valid_word_u got_word;
      ivec_t exp_rdy;
      bit    seen;
      int    lat;
      for (int p = 0; p < `PVT_NRPORT; p++) exp_word.ports[p] = ref_tbl[c[p]][r[p]];
      for (int k = 0; k < `PVT_NINST; k++) begin
         if (one[k]) begin
            exp_rdy[k] = exp_word.ports[2*k];   // Source A alone decides
         end else begin
            exp_rdy[k] = exp_word.ports[2*k] & exp_word.ports[2*k+1];
         end
      end
      @(posedge clka);
      rd_stb     <= 1'b1;
      rd_chk     <= c;
      rd_preg    <= r;
      rd_one_src <= one;
      @(posedge clka);
      rd_stb <= 1'b0;
      seen = 1'b0;
      lat  = 0;
      for (int n = 0; n < RESP_TIMEOUT && !seen; n++) begin
         @(negedge clka);   // Outputs settled
         if (rdy_stb) begin
            seen = 1'b1;
            lat  = n;
         end
      end
      if (!seen) begin
         stop_run("no response from the tracker: rdy_stb never rose after a read strobe");
      end
      if (lat != 0) begin
         stop_run($sformatf("rdy_stb came %0d cycles later than one cycle after the read", lat));
      end
      got_word.ports = src_valid;
      check_word("src_valid", got_word, exp_word);
      expect_ready("inst_rdy", inst_rdy, exp_rdy);
      @(negedge clka);   // Strobe lasts a single cycle
      if (rdy_stb) begin
         stop_run("rdy_stb stayed high for more than one cycle after a single read strobe");
      end
   endtask

   task automatic random_read(input int span);
      pvt_pkg::chkno_t  [`PVT_NRPORT-1:0] c;
      pvt_pkg::pregno_t [`PVT_NRPORT-1:0] r;
      for (int p = 0; p < `PVT_NRPORT; p++) begin
         c[p] = pvt_pkg::chkno_t'($urandom);
         r[p] = pvt_pkg::pregno_t'($urandom % span);
      end
      read_group(c, r, ivec_t'($urandom));
   endtask

   // Every port reads (c, r)
   task automatic broadcast_read(input pvt_pkg::chkno_t c, input pvt_pkg::pregno_t r);
      read_group({`PVT_NRPORT{c}}, {`PVT_NRPORT{r}}, ivec_t'($urandom));
   endtask

   // ========================================
   // Directed tests
   // ========================================

   task automatic reset_state_reads();
      for (int i = 0; i < 8; i++) random_read(`PVT_PREGS);
   endtask

   task automatic clear_and_set();
      pvt_pkg::chkno_t  [`PVT_NRPORT-1:0] cv;
      pvt_pkg::pregno_t r;
      pvt_pkg::chkno_t  c;
      r = pvt_pkg::pregno_t'($urandom);
      c = pvt_pkg::chkno_t'($urandom);
      for (int p = 0; p < `PVT_NRPORT; p++) cv[p] = pvt_pkg::chkno_t'((p / 2) % `PVT_NCHECK);
      single_write($urandom % `PVT_NWPORT, c, r, 1'b0);   // Allocate clears
      settle();
      read_group(cv, {`PVT_NRPORT{r}}, '0);               // Same register in every checkpoint
      single_write($urandom % `PVT_NWPORT, c, r, 1'b1);   // Writeback sets
      settle();
      read_group(cv, {`PVT_NRPORT{r}}, '0);
   endtask

   task automatic port_conflict();
      pvt_pkg::chkno_t  c;
      pvt_pkg::pregno_t r;
      c = pvt_pkg::chkno_t'($urandom);
      r = pvt_pkg::pregno_t'($urandom);
      write_cycle('1, {`PVT_NWPORT{c}}, {`PVT_NWPORT{r}}, wvec_t'(4'b0111));
      settle();
      broadcast_read(c, r);
      write_cycle('1, {`PVT_NWPORT{c}}, {`PVT_NWPORT{r}}, wvec_t'(4'b1000));
      settle();
      broadcast_read(c, r);
      write_cycle(wvec_t'(4'b0101), {`PVT_NWPORT{c}}, {`PVT_NWPORT{r}}, wvec_t'(4'b0001));
      settle();
      broadcast_read(c, r);
      for (int i = 0; i < 6; i++) begin
         write_cycle('1, {`PVT_NWPORT{c}}, {`PVT_NWPORT{r}}, wvec_t'($urandom));
         settle();
         broadcast_read(c, r);
      end
   endtask

   task automatic one_source_ready();
      pvt_pkg::chkno_t  c;
      pvt_pkg::pregno_t bad;
      pvt_pkg::pregno_t good;
      c    = pvt_pkg::chkno_t'($urandom);
      bad  = pvt_pkg::pregno_t'($urandom);
      good = bad + 1'b1;
      single_write(0, c, bad, 1'b0);
      single_write(1, c, good, 1'b1);
      settle();
      // Listed B then A from instruction 3 down to 0
      // Instruction 3 both bad, 2 only B good, 1 and 0 only A good
      read_group({`PVT_NRPORT{c}}, {bad, bad, good, bad, bad, good, bad, good},
                 ivec_t'(4'b0101));
      read_group({`PVT_NRPORT{c}}, {bad, bad, good, bad, bad, good, bad, good},
                 ivec_t'(4'b1010));
   endtask

   task automatic random_bursts();
      pvt_pkg::chkno_t  [`PVT_NWPORT-1:0] c;
      pvt_pkg::pregno_t [`PVT_NWPORT-1:0] r;
      int nwr;
      for (int n = 0; n < 24; n++) begin
         nwr = 1 + ($urandom % 4);   // One to four write cycles per burst
         for (int b = 0; b < nwr; b++) begin
            for (int i = 0; i < `PVT_NWPORT; i++) begin
               c[i] = pvt_pkg::chkno_t'($urandom);
               r[i] = pvt_pkg::pregno_t'($urandom % WINDOW);
            end
            write_cycle(wvec_t'($urandom), c, r, wvec_t'($urandom));
         end
         settle();
         random_read(WINDOW);
         random_read(WINDOW);
      end
   endtask

   // ========================================
   // Main sequence
   // ========================================

   initial begin
      void'($urandom(32'hded6));
      rst_n      = 1'b0;
      wr_stb     = '0;
      wr_chk     = '0;
      wr_preg    = '0;
      wr_val     = '0;
      rd_stb     = 1'b0;
      rd_chk     = '0;
      rd_preg    = '0;
      rd_one_src = '0;
      for (int c = 0; c < `PVT_NCHECK; c++) begin
         for (int r = 0; r < `PVT_PREGS; r++) ref_tbl[c][r] = 1'b1;   // All valid after reset
      end
      repeat (16) @(posedge clka);
      rst_n <= 1'b1;
      reset_state_reads();
      clear_and_set();
      port_conflict();
      one_source_ready();
      random_bursts();
      $display("Regression passed");
      $finish;
   end

endmodule

// File: vlog.f
+incdir+include
source/pvt_pkg.sv
source/valid_write_stage.sv
source/checkpoint_valid_ram.sv
source/operand_ready_gather.sv
source/preg_valid_tracker.sv
tests/tb_preg_valid_tracker.sv

// File: Makefile
# Verilator flow for the physical register valid tracker
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= vlog.f
RTL_TOP   ?= preg_valid_tracker
TB_TOP    ?= tb_preg_valid_tracker
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

# Lint the RTL top level
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# Build the testbench executable
build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

# Run, then judge the result from the log
sim: build
	-./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Regression passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation OK"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
